// File: sources.f
+incdir+rtl
rtl/vwrite_pkg.sv
rtl/burst_if.sv
rtl/apb_cfg_regs.sv
rtl/vwrite_ctrl.sv
rtl/store_addr_gen.sv
rtl/buffer_ram.sv
rtl/buffer_reader.sv
rtl/databus_writer.sv
rtl/vwrite_top.sv
sim/vwrite_tb.sv

// File: Bender.yml
package:
  name: vwrite

export_include_dirs:
  - rtl

sources:
  - rtl/vwrite_pkg.sv
  - rtl/burst_if.sv
  - rtl/apb_cfg_regs.sv
  - rtl/vwrite_ctrl.sv
  - rtl/store_addr_gen.sv
  - rtl/buffer_ram.sv
  - rtl/buffer_reader.sv
  - rtl/databus_writer.sv
  - rtl/vwrite_top.sv
  - target: simulation
    files:
      - sim/vwrite_tb.sv

// File: sim/vwrite_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_consts.svh"

module vwrite_tb import vwrite_pkg::*; ();

   localparam int BANK = `VW_BUF_ADDR_W - 1;
   localparam int DEPTH = 1 << `VW_BUF_ADDR_W;

   logic                      clk;
   logic                      rst;
   logic [`VW_APB_ADDR_W-1:0] paddr;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   word_t                     pwdata;
   word_t                     prdata;
   logic                      pready;
   logic                      in_valid;
   word_t                     in_data;
   logic                      databus_ready;
   logic                      databus_valid;
   ext_addr_t                 databus_addr;
   len_t                      databus_len;
   word_t                     databus_wdata;
   logic [`VW_DATA_W/8-1:0]   databus_wstrb;
   logic                      databus_last;
   logic                      done;

   // shadow of the buffer and marks for words written by the stream
   word_t     shadow [DEPTH];
   bit        known [DEPTH];
   logic      tb_pp;
   logic      cur_store_bank;
   logic      cur_read_bank;
   buf_addr_t cur_start;
   buf_addr_t cur_incr;
   buf_addr_t cur_shift;
   int        cur_per;
   ext_addr_t cur_ext;
   int        cur_total;
   int        cur_blen;
   int        beats_done;
   int        words_sent;
   int        burst_beat;
   bit        bp_on;
   word_t     rd;
   // beats seen by the databus slave
   ext_addr_t q_addr [$];
   len_t      q_len [$];
   word_t     q_data [$];

   vwrite_top uut (
      .clk             (clk),
      .rst             (rst),
      .paddr_i         (paddr),
      .psel_i          (psel),
      .penable_i       (penable),
      .pwrite_i        (pwrite),
      .pwdata_i        (pwdata),
      .prdata_o        (prdata),
      .pready_o        (pready),
      .in_valid_i      (in_valid),
      .in_data_i       (in_data),
      .databus_ready_i (databus_ready),
      .databus_valid_o (databus_valid),
      .databus_addr_o  (databus_addr),
      .databus_len_o   (databus_len),
      .databus_wdata_o (databus_wdata),
      .databus_wstrb_o (databus_wstrb),
      .databus_last_i  (databus_last),
      .done_o          (done)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_failure(string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
      if (actual !== expected) begin
         report_failure($sformatf("Error at %0t: %s is 0x%0h, expected 0x%0h",
            $time, name, actual, expected));
      end
   endtask

   // store address start + j*shift + i*incr with the bank bit from ping-pong
   function automatic buf_addr_t store_addr(int j, int i);
      buf_addr_t a;
      a = cur_start + buf_addr_t'(j) * cur_shift + buf_addr_t'(i) * cur_incr;
      a[BANK] = cur_store_bank;
      return a;
   endfunction

   // burst k starts at ext + 4*k*burst_len
   function automatic ext_addr_t beat_addr(int n);
      return cur_ext + ext_addr_t'(4 * (n / cur_blen) * cur_blen);
   endfunction

   // the final burst carries the remainder
   function automatic int beat_len(int n);
      int rem;
      rem = cur_total - (n / cur_blen) * cur_blen;
      return (rem < cur_blen) ? rem : cur_blen;
   endfunction

   task automatic apb_write(logic [`VW_APB_ADDR_W-1:0] addr, word_t data);
      @(posedge clk);
      #1;
      paddr   = addr;
      pwdata  = data;
      pwrite  = 1'b1;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(logic [`VW_APB_ADDR_W-1:0] addr, output word_t data);
      @(posedge clk);
      #1;
      paddr   = addr;
      pwrite  = 1'b0;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1;
      penable = 1'b1;
      // sample mid access cycle
      @(negedge clk);
      check_value("pready_o", pready, 1);
      data = prdata;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic write_readback(string name, logic [`VW_APB_ADDR_W-1:0] addr, word_t value);
      word_t data;
      apb_write(addr, value);
      apb_read(addr, data);
      check_value(name, data, value);
   endtask

   task automatic send_stream(int n);
      buf_addr_t a;
      word_t     w;
      for (int k = 0; k < n; k++) begin
         // random gap before some words
         if ($urandom_range(2) == 0) begin
            in_valid = 1'b0;
            @(posedge clk);
            #1;
         end
         w = $urandom;
         a = store_addr(k / cur_per, k % cur_per);
         shadow[a] = w;
         known[a]  = 1'b1;
         in_valid  = 1'b1;
         in_data   = w;
         words_sent++;
         @(posedge clk);
         #1;
      end
      in_valid = 1'b0;
   endtask

   task automatic wait_done_fall();
      int n;
      n = 0;
      do begin
         @(posedge clk);
         #1;
         n++;
      end while (done && n < 20);
      if (done) begin
         report_failure("Timeout: done_o did not fall after the run command");
      end
      check_value("done_o fall latency", n, 1);
   endtask

   task automatic wait_done_rise(int exp_words);
      int n;
      n = 0;
      while (!done && n < 4000) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!done) begin
         report_failure("Timeout: done_o did not rise at the end of the run");
      end
      // both sides must be complete when done rises
      check_value("stream words stored", words_sent, exp_words);
      check_value("databus beats", beats_done, cur_total);
   endtask

   task automatic do_run(logic pp, buf_addr_t start, buf_addr_t incr, int per, int iter,
                         buf_addr_t shift, int amount, int blen, ext_addr_t ext, bit bp);
      apb_write(`VW_REG_EXT_ADDR, ext);
      apb_write(`VW_REG_AMOUNT, word_t'(amount));
      apb_write(`VW_REG_BURST_LEN, word_t'(blen));
      apb_write(`VW_REG_START, word_t'(start));
      apb_write(`VW_REG_INCR, word_t'(incr));
      apb_write(`VW_REG_PER, word_t'(per));
      apb_write(`VW_REG_ITER, word_t'(iter));
      apb_write(`VW_REG_SHIFT, word_t'(shift));
      // bank state of the model
      tb_pp          = pp ? ~tb_pp : 1'b0;
      cur_store_bank = tb_pp;
      cur_read_bank  = pp & ~tb_pp;
      cur_start      = start;
      cur_incr       = incr;
      cur_shift      = shift;
      cur_per        = per;
      cur_ext        = ext;
      cur_total      = amount + 1;
      cur_blen       = blen;
      beats_done     = 0;
      words_sent     = 0;
      burst_beat     = 0;
      bp_on          = bp;
      check_value("done_o before run", done, 1);
      apb_write(`VW_REG_CTRL, word_t'({pp, 1'b1}));
      wait_done_fall();
      fork
         send_stream(per * iter);
         wait_done_rise(per * iter);
      join
   endtask

   // databus slave logs beats at the falling edge
   always @(negedge clk) begin
      if (!rst && databus_valid && databus_ready) begin
         check_value("databus_wstrb_o", databus_wstrb, 4'hF);
         q_addr.push_back(databus_addr);
         q_len.push_back(databus_len);
         q_data.push_back(databus_wdata);
         if (databus_last) begin
            burst_beat = 0;
         end else begin
            burst_beat++;
         end
      end
   end

   initial begin
      forever begin
         @(posedge clk);
         #1;
         databus_ready = bp_on ? ($urandom_range(99) < 55) : 1'b1;
         databus_last  = (burst_beat == int'(databus_len) - 1);
      end
   end

   initial begin : compare
      ext_addr_t a;
      len_t      l;
      word_t     w;
      buf_addr_t idx;
      forever begin
         @(posedge clk);
         while (q_addr.size() > 0) begin
            a = q_addr.pop_front();
            l = q_len.pop_front();
            w = q_data.pop_front();
            if (beats_done >= cur_total) begin
               report_failure("Databus beat seen after the end of the transfer");
            end
            check_value("databus_addr_o", a, beat_addr(beats_done));
            check_value("databus_len_o", l, beat_len(beats_done));
            idx = buf_addr_t'(beats_done);
            idx[BANK] = cur_read_bank;
            // words never stored have no expected value
            if (known[idx]) begin
               check_value("databus_wdata_o", w, shadow[idx]);
            end
            beats_done++;
         end
      end
   end

   initial begin
      void'($urandom(23));
      rst           = 1'b1;
      paddr         = '0;
      psel          = 1'b0;
      penable       = 1'b0;
      pwrite        = 1'b0;
      pwdata        = '0;
      in_valid      = 1'b0;
      in_data       = '0;
      databus_ready = 1'b1;
      databus_last  = 1'b0;
      bp_on         = 1'b0;
      tb_pp         = 1'b0;
      burst_beat    = 0;
      beats_done    = 0;
      cur_total     = 0;
      cur_blen      = 1;
      for (int k = 0; k < DEPTH; k++) begin
         known[k] = 1'b0;
      end
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;

      apb_read(`VW_REG_STATUS, rd);
      check_value("STATUS done after reset", rd, 1);
      write_readback("EXT_ADDR", `VW_REG_EXT_ADDR, 32'hA5A5_1234);
      write_readback("AMOUNT", `VW_REG_AMOUNT, 32'h0000_C003);
      write_readback("BURST_LEN", `VW_REG_BURST_LEN, 32'h0000_0017);
      write_readback("START", `VW_REG_START, 32'h0000_0155);
      write_readback("INCR", `VW_REG_INCR, 32'h0000_02AA);
      write_readback("PER", `VW_REG_PER, 32'h0000_1234);
      write_readback("ITER", `VW_REG_ITER, 32'h0000_BEEF);
      write_readback("SHIFT", `VW_REG_SHIFT, 32'h0000_03C3);
      write_readback("CTRL", `VW_REG_CTRL, 32'h0000_0002);

      // run 1 stores addresses 0..19 into bank 1 with a shift of -1
      do_run(1'b1, 10'd3, 10'd4, 5, 4, 10'h3FF, 10, 4, 32'h1000_0000, 1'b0);
      // run 2 sends run 1's bank in bursts 5,5,5,4
      do_run(1'b1, 10'd0, 10'd2, 10, 2, 10'd1, 18, 5, 32'h2000_0040, 1'b1);
      // run 3 must send run 2's data
      do_run(1'b1, 10'd7, 10'd5, 3, 5, 10'd2, 19, 8, 32'h3000_0100, 1'b1);
      // bank 0 read back with ping-pong off and an idle stream
      do_run(1'b0, 10'd0, 10'd0, 0, 0, 10'd0, 13, 4, 32'h4000_0200, 1'b1);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/vwrite_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_consts.svh"

module vwrite_top import vwrite_pkg::*; (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [`VW_APB_ADDR_W-1:0] paddr_i,
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  word_t                     pwdata_i,
   output word_t                     prdata_o,
   output logic                      pready_o,
   input  logic                      in_valid_i,
   input  word_t                     in_data_i,
   input  logic                      databus_ready_i,
   output logic                      databus_valid_o,
   output ext_addr_t                 databus_addr_o,
   output len_t                      databus_len_o,
   output word_t                     databus_wdata_o,
   output logic [`VW_DATA_W/8-1:0]   databus_wstrb_o,
   input  logic                      databus_last_i,
   output logic                      done_o
);

   vwrite_cfg_t cfg;
   logic        apb_run;
   logic        run;
   logic        store_bank;
   logic        read_bank;
   logic        store_done;
   logic        xfer_done;
   logic        wr_en;
   buf_addr_t   wr_addr;
   word_t       wr_data;
   logic        rd_en;
   buf_addr_t   rd_addr;
   word_t       rd_data;

   burst_if words ();

   apb_cfg_regs u_regs (
      .clk       (clk),
      .rst       (rst),
      .paddr_i   (paddr_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .pwdata_i  (pwdata_i),
      .done_i    (done_o),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .cfg_o     (cfg),
      .run_o     (apb_run)
   );

   vwrite_ctrl u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .run_i        (apb_run),
      .pingpong_i   (cfg.pingpong),
      .store_done_i (store_done),
      .xfer_done_i  (xfer_done),
      .run_o        (run),
      .store_bank_o (store_bank),
      .read_bank_o  (read_bank),
      .done_o       (done_o)
   );

   // store side
   store_addr_gen u_store (
      .clk        (clk),
      .rst        (rst),
      .run_i      (run),
      .cfg_i      (cfg),
      .bank_i     (store_bank),
      .in_valid_i (in_valid_i),
      .in_data_i  (in_data_i),
      .wr_en_o    (wr_en),
      .wr_addr_o  (wr_addr),
      .wr_data_o  (wr_data),
      .done_o     (store_done)
   );

   buffer_ram u_ram (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   // transfer side
   buffer_reader u_reader (
      .clk       (clk),
      .rst       (rst),
      .run_i     (run),
      .cfg_i     (cfg),
      .bank_i    (read_bank),
      .rd_data_i (rd_data),
      .rd_en_o   (rd_en),
      .rd_addr_o (rd_addr),
      .words     (words)
   );

   databus_writer u_writer (
      .clk             (clk),
      .rst             (rst),
      .run_i           (run),
      .cfg_i           (cfg),
      .databus_ready_i (databus_ready_i),
      .databus_last_i  (databus_last_i),
      .words           (words),
      .databus_valid_o (databus_valid_o),
      .databus_addr_o  (databus_addr_o),
      .databus_len_o   (databus_len_o),
      .databus_wdata_o (databus_wdata_o),
      .databus_wstrb_o (databus_wstrb_o),
      .done_o          (xfer_done)
   );

endmodule

`default_nettype wire

// File: rtl/databus_writer.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_consts.svh"

module databus_writer import vwrite_pkg::*; (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run_i,
   input  vwrite_cfg_t              cfg_i,
   input  logic                     databus_ready_i,
   input  logic                     databus_last_i,
   burst_if.sink                    words,
   output logic                     databus_valid_o,
   output ext_addr_t                databus_addr_o,
   output len_t                     databus_len_o,
   output word_t                    databus_wdata_o,
   output logic [`VW_DATA_W/8-1:0]  databus_wstrb_o,
   output logic                     done_o
);

   wr_state_e            state_q;
   ext_addr_t            addr_q;
   len_t                 len_q;
   // words still to send (one wider than amount)
   logic [`VW_COUNT_W:0] remain_q;
   logic                 done_q;
   logic                 beat;

   assign databus_valid_o = (state_q == WR_DATA) && words.valid;
   assign databus_addr_o  = addr_q;
   assign databus_len_o   = len_q;
   assign databus_wdata_o = words.data;
   assign databus_wstrb_o = '1;
   assign words.ready     = (state_q == WR_DATA) && databus_ready_i;
   assign beat            = databus_valid_o && databus_ready_i;
   assign done_o          = done_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q  <= WR_IDLE;
         done_q   <= 1'b1;
         addr_q   <= '0;
         len_q    <= '0;
         remain_q <= '0;
      end else if (run_i) begin
         state_q  <= WR_ADDR;
         done_q   <= 1'b0;
         addr_q   <= cfg_i.ext_addr;
         remain_q <= {1'b0, cfg_i.amount} + 1'b1;
      end else begin
         case (state_q)
            WR_ADDR: begin
               // short final burst takes the remainder
               if (remain_q > cfg_i.burst_len) begin
                  len_q <= cfg_i.burst_len;
               end else begin
                  len_q <= len_t'(remain_q);
               end
               state_q <= WR_DATA;
            end
            WR_DATA: begin
               if (beat) begin
                  remain_q <= remain_q - 1'b1;
                  if (words.last) begin
                     state_q <= WR_IDLE;
                     done_q  <= 1'b1;
                  end else if (databus_last_i) begin
                     addr_q  <= addr_q + ext_addr_t'({cfg_i.burst_len, 2'b00});
                     state_q <= WR_ADDR;
                  end
               end
            end
            default: ;
         endcase
      end
   end

   // request and data held under back-pressure
   a_valid_held: assert property (@(posedge clk) disable iff (rst)
      databus_valid_o && !databus_ready_i |=> databus_valid_o
         && $stable(databus_addr_o) && $stable(databus_len_o)
         && $stable(databus_wdata_o));

endmodule

`default_nettype wire

// File: rtl/buffer_reader.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_consts.svh"

module buffer_reader import vwrite_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        run_i,
   input  vwrite_cfg_t cfg_i,
   input  logic        bank_i,
   input  word_t       rd_data_i,
   output logic        rd_en_o,
   output buf_addr_t   rd_addr_o,
   burst_if.source     words
);

   localparam int BANK = `VW_BUF_ADDR_W - 1;

   logic       active_q;
   count_t     idx_q;
   // read issued last cycle, its data arrives now
   logic       pend_q;
   logic       pend_last_q;
   word_t      ent_data_q [2];
   logic       ent_last_q [2];
   logic       wr_ptr_q;
   logic       rd_ptr_q;
   logic [1:0] cnt_q;
   logic       issue;
   logic       issue_last;
   logic       pop;

   assign pop        = words.valid & words.ready;
   assign issue_last = (idx_q == cfg_i.amount);
   // a word leaving frees a slot for the new read
   assign issue      = active_q && ((3'(cnt_q) + 3'(pend_q)) < (3'd2 + 3'(pop)));

   assign rd_en_o     = issue;
   assign rd_addr_o   = {bank_i, idx_q[BANK-1:0]};
   assign words.valid = (cnt_q != 2'd0);
   assign words.data  = ent_data_q[rd_ptr_q];
   assign words.last  = ent_last_q[rd_ptr_q];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active_q    <= 1'b0;
         idx_q       <= '0;
         pend_q      <= 1'b0;
         pend_last_q <= 1'b0;
         wr_ptr_q    <= 1'b0;
         rd_ptr_q    <= 1'b0;
         cnt_q       <= 2'd0;
      end else if (run_i) begin
         active_q <= 1'b1;
         idx_q    <= '0;
         pend_q   <= 1'b0;
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         cnt_q    <= 2'd0;
      end else begin
         pend_q      <= issue;
         pend_last_q <= issue_last;
         if (issue) begin
            idx_q <= idx_q + 1'b1;
            if (issue_last) active_q <= 1'b0;
         end
         if (pend_q) wr_ptr_q <= ~wr_ptr_q;
         if (pop) rd_ptr_q <= ~rd_ptr_q;
         cnt_q <= cnt_q + 2'(pend_q) - 2'(pop);
      end
   end

   // holding entries
   always_ff @(posedge clk) begin
      if (pend_q) begin
         ent_data_q[wr_ptr_q] <= rd_data_i;
         ent_last_q[wr_ptr_q] <= pend_last_q;
      end
   end

   a_amount_fits: assert property (@(posedge clk) disable iff (rst)
      run_i |-> cfg_i.amount < count_t'(1 << BANK));

endmodule

`default_nettype wire

// File: rtl/buffer_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_consts.svh"

module buffer_ram import vwrite_pkg::*; (
   input  logic      clk,
   input  logic      wr_en_i,
   input  buf_addr_t wr_addr_i,
   input  word_t     wr_data_i,
   input  logic      rd_en_i,
   input  buf_addr_t rd_addr_i,
   output word_t     rd_data_o
);

   localparam int DEPTH = 1 << `VW_BUF_ADDR_W;

   // both banks in one array
   word_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
      // read data one cycle after the enable
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

`default_nettype wire

// File: rtl/store_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_consts.svh"

module store_addr_gen import vwrite_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        run_i,
   input  vwrite_cfg_t cfg_i,
   input  logic        bank_i,
   input  logic        in_valid_i,
   input  word_t       in_data_i,
   output logic        wr_en_o,
   output buf_addr_t   wr_addr_o,
   output word_t       wr_data_o,
   output logic        done_o
);

   localparam int BANK = `VW_BUF_ADDR_W - 1;

   logic      active_q;
   logic      done_q;
   count_t    i_q;
   count_t    j_q;
   // base of the current outer step (start + j*shift)
   buf_addr_t row_q;
   buf_addr_t addr_q;
   logic      accept;

   assign accept    = active_q & in_valid_i;
   assign wr_en_o   = accept;
   assign wr_addr_o = {bank_i, addr_q[BANK-1:0]};
   assign wr_data_o = in_data_i;
   assign done_o    = done_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active_q <= 1'b0;
         done_q   <= 1'b1;
         i_q      <= '0;
         j_q      <= '0;
         row_q    <= '0;
         addr_q   <= '0;
      end else if (run_i) begin
         // empty loop finishes at once
         active_q <= (cfg_i.per != '0) && (cfg_i.iter != '0);
         done_q   <= (cfg_i.per == '0) || (cfg_i.iter == '0);
         i_q      <= '0;
         j_q      <= '0;
         row_q    <= cfg_i.start;
         addr_q   <= cfg_i.start;
      end else if (accept) begin
         if (i_q == cfg_i.per - 1'b1) begin
            i_q <= '0;
            if (j_q == cfg_i.iter - 1'b1) begin
               active_q <= 1'b0;
               done_q   <= 1'b1;
            end else begin
               j_q    <= j_q + 1'b1;
               row_q  <= row_q + cfg_i.shift;
               addr_q <= row_q + cfg_i.shift;
            end
         end else begin
            i_q    <= i_q + 1'b1;
            addr_q <= addr_q + cfg_i.incr;
         end
      end
   end

   // the pattern must stay inside one bank while ping-pong owns the bank bit
   a_bank_overflow: assert property (@(posedge clk) disable iff (rst)
      accept && cfg_i.pingpong |-> !addr_q[BANK]);

endmodule

`default_nettype wire

// File: rtl/vwrite_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_consts.svh"

module vwrite_ctrl import vwrite_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic run_i,
   input  logic pingpong_i,
   input  logic store_done_i,
   input  logic xfer_done_i,
   output logic run_o,
   output logic store_bank_o,
   output logic read_bank_o,
   output logic done_o
);

   ctrl_state_e state_q;
   logic        run_q;
   logic        pp_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         run_q   <= 1'b0;
         pp_q    <= 1'b0;
         state_q <= CTRL_IDLE;
      end else begin
         run_q <= run_i;
         // banks swap on every run and park at 0 without ping-pong
         if (run_q) begin
            pp_q <= pingpong_i ? ~pp_q : 1'b0;
         end
         case (state_q)
            CTRL_IDLE: if (run_q) state_q <= CTRL_BUSY;
            CTRL_BUSY: if (store_done_i && xfer_done_i) state_q <= CTRL_IDLE;
            default:   state_q <= CTRL_IDLE;
         endcase
      end
   end

   assign run_o        = run_q;
   assign store_bank_o = pp_q;
   // previous run's bank or bank 0 when both sides share it
   assign read_bank_o  = pingpong_i & ~pp_q;
   assign done_o       = (state_q == CTRL_IDLE);

   // a new run only once the previous one has fully finished
   a_run_idle: assert property (@(posedge clk) disable iff (rst)
      run_i |-> (state_q == CTRL_IDLE) && !run_q);

endmodule

`default_nettype wire

// File: rtl/apb_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "vwrite_consts.svh"

module apb_cfg_regs import vwrite_pkg::*; (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [`VW_APB_ADDR_W-1:0] paddr_i,
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  word_t                     pwdata_i,
   input  logic                      done_i,
   output word_t                     prdata_o,
   output logic                      pready_o,
   output vwrite_cfg_t               cfg_o,
   output logic                      run_o
);

   logic wr_en;

   // no wait states
   assign pready_o = 1'b1;
   assign wr_en    = psel_i & penable_i & pwrite_i;
   // run pulse decoded from the access cycle itself
   assign run_o    = wr_en && (paddr_i == `VW_REG_CTRL) && pwdata_i[0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg_o <= '0;
      end else if (wr_en) begin
         case (paddr_i)
            `VW_REG_CTRL:      cfg_o.pingpong  <= pwdata_i[1];
            `VW_REG_EXT_ADDR:  cfg_o.ext_addr  <= pwdata_i;
            `VW_REG_AMOUNT:    cfg_o.amount    <= pwdata_i[`VW_COUNT_W-1:0];
            `VW_REG_BURST_LEN: cfg_o.burst_len <= pwdata_i[`VW_LEN_W-1:0];
            `VW_REG_START:     cfg_o.start     <= pwdata_i[`VW_BUF_ADDR_W-1:0];
            `VW_REG_INCR:      cfg_o.incr      <= pwdata_i[`VW_BUF_ADDR_W-1:0];
            `VW_REG_PER:       cfg_o.per       <= pwdata_i[`VW_COUNT_W-1:0];
            `VW_REG_ITER:      cfg_o.iter      <= pwdata_i[`VW_COUNT_W-1:0];
            `VW_REG_SHIFT:     cfg_o.shift     <= pwdata_i[`VW_BUF_ADDR_W-1:0];
            default: ;
         endcase
      end
   end

   // run bit always reads back as zero
   always_comb begin
      case (paddr_i)
         `VW_REG_CTRL:      prdata_o = word_t'({cfg_o.pingpong, 1'b0});
         `VW_REG_STATUS:    prdata_o = word_t'(done_i);
         `VW_REG_EXT_ADDR:  prdata_o = word_t'(cfg_o.ext_addr);
         `VW_REG_AMOUNT:    prdata_o = word_t'(cfg_o.amount);
         `VW_REG_BURST_LEN: prdata_o = word_t'(cfg_o.burst_len);
         `VW_REG_START:     prdata_o = word_t'(cfg_o.start);
         `VW_REG_INCR:      prdata_o = word_t'(cfg_o.incr);
         `VW_REG_PER:       prdata_o = word_t'(cfg_o.per);
         `VW_REG_ITER:      prdata_o = word_t'(cfg_o.iter);
         `VW_REG_SHIFT:     prdata_o = word_t'(cfg_o.shift);
         default:           prdata_o = '0;
      endcase
   end

   a_penable_psel: assert property (@(posedge clk) disable iff (rst)
      penable_i |-> psel_i);

endmodule

`default_nettype wire

// File: rtl/burst_if.sv
`timescale 1ns/1ps
`default_nettype none

// buffered words from the reader to the databus writer
interface burst_if import vwrite_pkg::*; ();

   logic  valid;
   logic  ready;
   word_t data;
   // final word of the whole transfer
   logic  last;

   modport source (
      output valid,
      output data,
      output last,
      input  ready
   );

   modport sink (
      input  valid,
      input  data,
      input  last,
      output ready
   );

endinterface

`default_nettype wire

// File: rtl/vwrite_pkg.sv
`default_nettype none
`include "vwrite_consts.svh"

package vwrite_pkg;

   typedef logic [`VW_DATA_W-1:0]     word_t;
   typedef logic [`VW_BUF_ADDR_W-1:0] buf_addr_t;
   typedef logic [`VW_EXT_ADDR_W-1:0] ext_addr_t;
   typedef logic [`VW_COUNT_W-1:0]    count_t;
   typedef logic [`VW_LEN_W-1:0]      len_t;

   typedef struct packed {
      logic      pingpong;
      ext_addr_t ext_addr;
      // words to transfer minus one
      count_t    amount;
      len_t      burst_len;
      buf_addr_t start;
      buf_addr_t incr;
      count_t    per;
      count_t    iter;
      buf_addr_t shift;
   } vwrite_cfg_t;

   typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA} wr_state_e;
   typedef enum logic {CTRL_IDLE, CTRL_BUSY} ctrl_state_e;

endpackage

`default_nettype wire

// File: rtl/vwrite_consts.svh
`ifndef VWRITE_CONSTS_SVH
`define VWRITE_CONSTS_SVH

`define VW_DATA_W      32
// top bit of a buffer address selects the bank
`define VW_BUF_ADDR_W  10
`define VW_EXT_ADDR_W  32
`define VW_COUNT_W     16
`define VW_LEN_W       8
`define VW_APB_ADDR_W  8

// apb register byte offsets
`define VW_REG_CTRL      8'h00
`define VW_REG_STATUS    8'h04
`define VW_REG_EXT_ADDR  8'h08
`define VW_REG_AMOUNT    8'h0C
`define VW_REG_BURST_LEN 8'h10
`define VW_REG_START     8'h14
`define VW_REG_INCR      8'h18
`define VW_REG_PER       8'h1C
`define VW_REG_ITER      8'h20
`define VW_REG_SHIFT     8'h24

`endif
